// ==== verilog/stage2_macros.svh ====
`ifndef STAGE2_MACROS_SVH
`define STAGE2_MACROS_SVH

// ============================================================
// frame geometry
// ============================================================
`define ST2_POOL_X        24
`define ST2_POOL_Y        24

// ============================================================
// datapath widths
// ============================================================
// pooled pixel after relu and saturation
`define ST2_POOL_IBW      20
// conv accumulator sample and bias
`define ST2_ACC_BW        24

// ============================================================
// result fifo
// ============================================================
`define ST2_FIFO_DEPTH    16
// free slots kept back for samples still in the pipe
`define ST2_FIFO_MARGIN   3

`endif

// ==== verilog/stage2_types_pkg.sv ====
`include "stage2_macros.svh"

package stage2_types_pkg;

    // ============================================================
    // datapath payload types
    // ============================================================

    // raw conv accumulator sample, two's complement
    typedef logic signed [`ST2_ACC_BW-1:0] acc_t;

    // programmable bias, same width as the accumulator
    typedef logic signed [`ST2_ACC_BW-1:0] bias_t;

    // one extra bit so acc + bias never wraps
    typedef logic signed [`ST2_ACC_BW:0] sum_t;

    // activated / pooled pixel, always non-negative
    typedef logic [`ST2_POOL_IBW-1:0] pix_t;

    // saturation ceiling
    localparam pix_t PIX_MAX = '1;

endpackage

// ==== verilog/stage2_ctrl_pkg.sv ====
package stage2_ctrl_pkg;

    // ============================================================
    // handshake controller states
    // ============================================================

    // input side, four-phase receiver
    typedef enum logic {
        IDLE,
        WAIT_REQ_LOW
    } rx_state_t;

    // output side, four-phase sender on the fifo head
    typedef enum logic [1:0] {
        EMPTY,
        REQ_HIGH,
        WAIT_ACK_LOW
    } tx_state_t;

endpackage

// ==== verilog/stage2_sample_rx.sv ====
`timescale 1ns/1ps

module stage2_sample_rx (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_req,
    input  stage2_types_pkg::acc_t     i_data,
    input  logic                       i_almost_full,
    output logic                       o_ack,
    output logic                       o_valid,
    output stage2_types_pkg::acc_t     o_data
);

    stage2_ctrl_pkg::rx_state_t state;

    // set on the edge that raises ack, feeds the valid pulse
    logic take;

    // ============================================================
    // four-phase handshake fsm
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= stage2_ctrl_pkg::IDLE;
            o_ack <= 1'b0;
            take  <= 1'b0;
        end else begin
            take <= 1'b0;
            case (state)
                stage2_ctrl_pkg::IDLE: begin
                    // hold off while the fifo is close to full
                    if (i_req && !i_almost_full) begin
                        o_ack <= 1'b1;
                        take  <= 1'b1;
                        state <= stage2_ctrl_pkg::WAIT_REQ_LOW;
                    end
                end
                stage2_ctrl_pkg::WAIT_REQ_LOW: begin
                    // sender dropped req, release ack
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= stage2_ctrl_pkg::IDLE;
                    end
                end
                default: begin
                    o_ack <= 1'b0;
                    state <= stage2_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // one valid per handshake, a cycle after ack rises
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= take;
        end
    end

    // capture sample while req still holds it stable
    always_ff @(posedge clk) begin
        if (state == stage2_ctrl_pkg::IDLE && i_req && !i_almost_full) begin
            o_data <= i_data;
        end
    end

endmodule

// ==== verilog/stage2_activation.sv ====
`timescale 1ns/1ps

`include "stage2_macros.svh"

module stage2_activation (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_valid,
    input  stage2_types_pkg::acc_t     i_acc,
    input  stage2_types_pkg::bias_t    i_bias,
    output logic                       o_valid,
    output stage2_types_pkg::pix_t     o_pix
);

    stage2_types_pkg::sum_t sum;
    stage2_types_pkg::pix_t pix_next;

    // ============================================================
    // bias add, relu, saturate
    // ============================================================

    // sign-extend both operands before the add
    always_comb begin
        sum = stage2_types_pkg::sum_t'(i_acc) + stage2_types_pkg::sum_t'(i_bias);
    end

    always_comb begin
        if (sum[`ST2_ACC_BW]) begin
            // negative, relu
            pix_next = '0;
        end else if (|sum[`ST2_ACC_BW-1:`ST2_POOL_IBW]) begin
            // bits above pixel range set, clamp
            pix_next = stage2_types_pkg::PIX_MAX;
        end else begin
            pix_next = sum[`ST2_POOL_IBW-1:0];
        end
    end

    // ============================================================
    // output register, one cycle latency
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_pix <= pix_next;
        end
    end

endmodule

// ==== verilog/stage2_pooling.sv ====
`timescale 1ns/1ps

`include "stage2_macros.svh"

module stage2_pooling #(
    parameter int COLS = `ST2_POOL_X,
    parameter int ROWS = `ST2_POOL_Y
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_valid,
    input  stage2_types_pkg::pix_t     i_pix,
    output logic                       o_valid,
    output stage2_types_pkg::pix_t     o_pix
);

    localparam int COL_W = $clog2(COLS);
    localparam int ROW_W = $clog2(ROWS);

    // raster position of the incoming pixel
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col_left;

    // current row being filled, and the row above it
    stage2_types_pkg::pix_t cur_line  [COLS];
    stage2_types_pkg::pix_t prev_line [COLS];

    // window closes on odd row, odd column
    logic window_done;
    stage2_types_pkg::pix_t window_max;

    // ============================================================
    // max of two pixels
    // ============================================================
    function automatic stage2_types_pkg::pix_t pix_max(
        input stage2_types_pkg::pix_t a,
        input stage2_types_pkg::pix_t b
    );
        return (a > b) ? a : b;
    endfunction

    // ============================================================
    // row / column counters
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (i_valid) begin
            if (col == COL_W'(COLS - 1)) begin
                col <= '0;
                // wrap at frame end, next frame starts at row 0
                if (row == ROW_W'(ROWS - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ============================================================
    // line buffers
    // ============================================================

    // start of a row pushes the finished row into prev_line
    always_ff @(posedge clk) begin
        if (i_valid && col == '0) begin
            for (int i = 0; i < COLS; i++) begin
                prev_line[i] <= cur_line[i];
            end
        end
    end

    // store each pixel at its column
    always_ff @(posedge clk) begin
        if (i_valid) begin
            cur_line[col] <= i_pix;
        end
    end

    // ============================================================
    // 2x2 window max
    // ============================================================
    assign col_left    = col - 1'b1;
    assign window_done = i_valid && row[0] && col[0];

    // incoming pixel is the bottom-right corner
    always_comb begin
        window_max = pix_max(pix_max(prev_line[col_left], prev_line[col]),
                             pix_max(cur_line[col_left], i_pix));
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= window_done;
        end
    end

    always_ff @(posedge clk) begin
        if (window_done) begin
            o_pix <= window_max;
        end
    end

endmodule

// ==== verilog/stage2_result_fifo.sv ====
`timescale 1ns/1ps

`include "stage2_macros.svh"

module stage2_result_fifo (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       i_wr_valid,
    input  stage2_types_pkg::pix_t     i_wr_pix,
    output logic                       o_almost_full,
    output logic                       o_req,
    output stage2_types_pkg::pix_t     o_data,
    input  logic                       i_ack
);

    localparam int DEPTH = `ST2_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    stage2_types_pkg::pix_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic push;
    logic pop;
    logic load;

    stage2_ctrl_pkg::tx_state_t state;

    // ============================================================
    // occupancy flags
    // ============================================================
    assign full          = (count == CNT_W'(DEPTH));
    // fewer than MARGIN slots left
    assign o_almost_full = (CNT_W'(DEPTH) - count) < CNT_W'(`ST2_FIFO_MARGIN);

    assign push = i_wr_valid && !full;
    // head leaves when the far side acks
    assign pop  = (state == stage2_ctrl_pkg::REQ_HIGH) && i_ack;
    // head latched into o_data when a new transfer starts
    assign load = (state == stage2_ctrl_pkg::EMPTY) && (count != '0);

    // ============================================================
    // storage and pointers
    // ============================================================
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_pix;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // ============================================================
    // four-phase sender on the read side
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= stage2_ctrl_pkg::EMPTY;
            o_req <= 1'b0;
        end else begin
            case (state)
                stage2_ctrl_pkg::EMPTY: begin
                    if (load) begin
                        o_req <= 1'b1;
                        state <= stage2_ctrl_pkg::REQ_HIGH;
                    end
                end
                stage2_ctrl_pkg::REQ_HIGH: begin
                    if (i_ack) begin
                        o_req <= 1'b0;
                        state <= stage2_ctrl_pkg::WAIT_ACK_LOW;
                    end
                end
                stage2_ctrl_pkg::WAIT_ACK_LOW: begin
                    // wait out the ack before the next req
                    if (!i_ack) begin
                        state <= stage2_ctrl_pkg::EMPTY;
                    end
                end
                default: begin
                    o_req <= 1'b0;
                    state <= stage2_ctrl_pkg::EMPTY;
                end
            endcase
        end
    end

    // data held from req rise through ack fall
    always_ff @(posedge clk) begin
        if (load) begin
            o_data <= mem[rd_ptr];
        end
    end

endmodule

// ==== verilog/stage2_pool_core.sv ====
`timescale 1ns/1ps

module stage2_pool_core (
    input  logic                       clk,
    input  logic                       reset_n,
    input  stage2_types_pkg::bias_t    i_bias,
    input  logic                       i_in_req,
    input  stage2_types_pkg::acc_t     i_in_data,
    output logic                       o_in_ack,
    output logic                       o_out_req,
    output stage2_types_pkg::pix_t     o_out_data,
    input  logic                       i_out_ack
);

    // receiver to activation
    logic                       rx_valid;
    stage2_types_pkg::acc_t     rx_data;

    // activation to pooling
    logic                       act_valid;
    stage2_types_pkg::pix_t     act_pix;

    // pooling to fifo
    logic                       pool_valid;
    stage2_types_pkg::pix_t     pool_pix;

    // fifo back-pressure to receiver
    logic                       fifo_almost_full;

    // ============================================================
    // input link
    // ============================================================
    stage2_sample_rx stage2_sample_rx_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_req         (i_in_req),
        .i_data        (i_in_data),
        .i_almost_full (fifo_almost_full),
        .o_ack         (o_in_ack),
        .o_valid       (rx_valid),
        .o_data        (rx_data)
    );

    // ============================================================
    // datapath
    // ============================================================
    stage2_activation stage2_activation_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .i_valid (rx_valid),
        .i_acc   (rx_data),
        .i_bias  (i_bias),
        .o_valid (act_valid),
        .o_pix   (act_pix)
    );

    // frame size from the macro defaults
    stage2_pooling stage2_pooling_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .i_valid (act_valid),
        .i_pix   (act_pix),
        .o_valid (pool_valid),
        .o_pix   (pool_pix)
    );

    // ============================================================
    // result buffer and output link
    // ============================================================
    stage2_result_fifo stage2_result_fifo_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .i_wr_valid    (pool_valid),
        .i_wr_pix      (pool_pix),
        .o_almost_full (fifo_almost_full),
        .o_req         (o_out_req),
        .o_data        (o_out_data),
        .i_ack         (i_out_ack)
    );

endmodule

// ==== verification/stage2_pool_core_tb.sv ====
`timescale 1ns/1ps

`include "stage2_macros.svh"

module stage2_pool_core_tb;

    localparam int X         = `ST2_POOL_X;
    localparam int Y         = `ST2_POOL_Y;
    localparam int NPIX      = X * Y;
    localparam int NPOOL     = NPIX / 4;
    localparam int NUM_FRAMES = 5;
    // frames x samples x cycles per sample x clock period, plus margin
    localparam longint WATCHDOG_NS = longint'(NUM_FRAMES) * NPIX * 40 * 20 + 200000;

    logic                    clk;
    logic                    reset_n;
    stage2_types_pkg::bias_t i_bias;
    logic                    i_in_req;
    stage2_types_pkg::acc_t  i_in_data;
    logic                    o_in_ack;
    logic                    o_out_req;
    stage2_types_pkg::pix_t  o_out_data;
    logic                    i_out_ack;

    // stimulus frame and scoreboard
    stage2_types_pkg::acc_t  frame [NPIX];
    stage2_types_pkg::pix_t  expected_q [$];
    string                   name_q [$];
    string                   cur_test;

    logic [15:0] data_lfsr = 16'd14;
    logic [15:0] ack_lfsr  = 16'd14;
    // -1 selects a random ack delay
    int fixed_delay = -1;
    int out_count   = 0;

    int value_errors    = 0;
    int protocol_errors = 0;
    int count_errors    = 0;

    logic                   prev_req;
    stage2_types_pkg::pix_t prev_data;

    stage2_pool_core stage2_pool_core_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_bias     (i_bias),
        .i_in_req   (i_in_req),
        .i_in_data  (i_in_data),
        .o_in_ack   (o_in_ack),
        .o_out_req  (o_out_req),
        .o_out_data (o_out_data),
        .i_out_ack  (i_out_ack)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ============================================================
    // random source
    // ============================================================

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] data_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            r = {r[30:0], data_lfsr[0]};
        end
        return r;
    endfunction

    // separate stream so the ack side never races the stimulus side
    function automatic logic [31:0] delay_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            ack_lfsr = lfsr_next(ack_lfsr);
            r = {r[30:0], ack_lfsr[0]};
        end
        return r;
    endfunction

    // ============================================================
    // reference model
    // ============================================================

    // bias, relu, clamp at the 20-bit ceiling
    function automatic stage2_types_pkg::pix_t act_ref(
        input stage2_types_pkg::acc_t  a,
        input stage2_types_pkg::bias_t b
    );
        longint s;
        longint pmax;
        s    = longint'(a) + longint'(b);
        pmax = (longint'(1) << `ST2_POOL_IBW) - 1;
        if (s < 0) begin
            return '0;
        end else if (s > pmax) begin
            return stage2_types_pkg::pix_t'(pmax);
        end
        return stage2_types_pkg::pix_t'(s);
    endfunction

    // max of every 2x2 window, raster order
    task automatic expect_frame(input stage2_types_pkg::bias_t b);
        stage2_types_pkg::pix_t m;
        stage2_types_pkg::pix_t p;
        for (int r = 0; r < Y; r += 2) begin
            for (int c = 0; c < X; c += 2) begin
                m = '0;
                for (int k = 0; k < 4; k++) begin
                    p = act_ref(frame[(r + k / 2) * X + c + k % 2], b);
                    if (p > m) begin
                        m = p;
                    end
                end
                expected_q.push_back(m);
                name_q.push_back(cur_test);
            end
        end
    endtask

    // ============================================================
    // frame generators
    // ============================================================
    task automatic fill_negative();
        for (int i = 0; i < NPIX; i++) begin
            frame[i] = -stage2_types_pkg::acc_t'(1 + data_bits(16));
        end
    endtask

    // everything at or above 2^20 before the bias
    task automatic fill_large();
        for (int i = 0; i < NPIX; i++) begin
            frame[i] = stage2_types_pkg::acc_t'(24'h100000 + data_bits(19));
        end
    endtask

    // 22-bit signed spread gives zeros, clamps and in-range pixels
    task automatic fill_random();
        logic [21:0] r;
        for (int i = 0; i < NPIX; i++) begin
            r = data_bits(22);
            frame[i] = {{2{r[21]}}, r};
        end
    endtask

    // ============================================================
    // input link driver
    // ============================================================

    // entered on a rising edge, req rises on the edge that saw ack low
    // four cycles per sample, fast enough to outrun a slow output side
    task automatic send_sample(input stage2_types_pkg::acc_t v);
        i_in_req  <= 1'b1;
        i_in_data <= v;
        @(posedge clk);
        while (!o_in_ack) @(posedge clk);
        i_in_req <= 1'b0;
        @(posedge clk);
        while (o_in_ack) @(posedge clk);
    endtask

    task automatic send_frame();
        for (int i = 0; i < NPIX; i++) begin
            send_sample(frame[i]);
        end
    endtask

    // ============================================================
    // output link and compare
    // ============================================================
    task automatic check_output(input stage2_types_pkg::pix_t got);
        stage2_types_pkg::pix_t exp;
        string name;
        out_count++;
        if (expected_q.size() == 0) begin
            $display("extra pooled pixel %0h arrived with nothing expected", got);
            count_errors++;
        end else begin
            exp  = expected_q.pop_front();
            name = name_q.pop_front();
            if (got !== exp) begin
                $display("FAILED %s: expected %0h actual %0h", name, exp, got);
                value_errors++;
            end
        end
    endtask

    initial begin : ack_responder
        int delay;
        forever begin
            @(posedge clk);
            if (o_out_req) begin
                if (fixed_delay >= 0) begin
                    delay = fixed_delay;
                end else begin
                    delay = int'(delay_bits(4));
                end
                repeat (delay) @(posedge clk);
                check_output(o_out_data);
                i_out_ack <= 1'b1;
                @(posedge clk);
                while (o_out_req) @(posedge clk);
                i_out_ack <= 1'b0;
            end
        end
    end

    // data must hold while req is up
    always @(posedge clk) begin
        if (reset_n && o_out_req && prev_req && o_out_data !== prev_data) begin
            $display("FAILED protocol: expected %0h actual %0h", prev_data, o_out_data);
            protocol_errors++;
        end
        prev_req  <= o_out_req;
        prev_data <= o_out_data;
    end

    // ============================================================
    // end of test drain
    // ============================================================
    task automatic wait_drained(input int frames);
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < frames * 5000) begin
            @(posedge clk);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("test %s ended with %0d pooled pixels never delivered",
                     cur_test, expected_q.size());
            count_errors++;
            expected_q.delete();
            name_q.delete();
        end
        // room for a stray extra output to show up
        repeat (40) @(posedge clk);
        if (out_count != frames * NPOOL) begin
            $display("FAILED %s count: expected %0d actual %0d",
                     cur_test, frames * NPOOL, out_count);
            count_errors++;
        end
        out_count = 0;
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired, the DUT stopped handshaking");
        $display("Some tests failed");
        $finish;
    end

    // ============================================================
    // main sequence
    // ============================================================
    initial begin : main_flow
        stage2_types_pkg::bias_t b;
        logic [19:0] r;
        reset_n   = 1'b0;
        i_bias    = '0;
        i_in_req  = 1'b0;
        i_in_data = '0;
        i_out_ack = 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);

        if (o_in_ack !== 1'b0 || o_out_req !== 1'b0) begin
            $display("FAILED reset_idle: expected 00 actual %b%b", o_in_ack, o_out_req);
            value_errors++;
        end

        // negative samples, zero bias
        cur_test = "relu";
        fill_negative();
        i_bias <= '0;
        expect_frame('0);
        send_frame();
        wait_drained(1);

        // pushed past the pixel ceiling
        cur_test = "saturation";
        fill_large();
        b = 24'sh001000;
        i_bias <= b;
        expect_frame(b);
        send_frame();
        wait_drained(1);

        // two back-to-back frames, counters wrap in between
        cur_test = "pooling";
        for (int f = 0; f < 2; f++) begin
            fill_random();
            r = data_bits(20);
            b = {{4{r[19]}}, r};
            i_bias <= b;
            expect_frame(b);
            send_frame();
        end
        wait_drained(2);

        // slow far side fills the fifo
        cur_test = "backpressure";
        fixed_delay = 15;
        fill_random();
        r = data_bits(20);
        b = {{4{r[19]}}, r};
        i_bias <= b;
        expect_frame(b);
        send_frame();
        wait_drained(1);
        fixed_delay = -1;

        $display("errors: value %0d, protocol %0d, count %0d",
                 value_errors, protocol_errors, count_errors);
        if (value_errors + protocol_errors + count_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/stage2_types_pkg.sv
verilog/stage2_ctrl_pkg.sv
verilog/stage2_sample_rx.sv
verilog/stage2_activation.sv
verilog/stage2_pooling.sv
verilog/stage2_result_fifo.sv
verilog/stage2_pool_core.sv
verification/stage2_pool_core_tb.sv
